/* filelist.f */
hw/fc_lcc_svc_pkg.sv
hw/svc_cmd_decoder.sv
hw/lc_override_regs.sv
hw/lcc_clk_switch_ctrl.sv
hw/fc_lcc_reset_seq.sv
hw/otp_fault_injector.sv
hw/otp_mem_model.sv
hw/fc_lcc_svc_top.sv
testbench/fc_lcc_svc_properties.sv
testbench/fc_lcc_svc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the service block testbench with Verilator, then judges the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module fc_lcc_svc_tb \
  && ./obj_dir/Vfc_lcc_svc_tb > sim.log 2>&1 \
  || echo "Build or simulation ended with an error status"
cat sim.log 2>/dev/null
grep -q "Simulation finished: FAIL" sim.log 2>/dev/null && { echo "Test failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log 2>/dev/null || { echo "Test failed, no pass line"; exit 1; }
echo "Test passed"

/* testbench/fc_lcc_svc_tb.sv */
// Table-driven testbench for the fuse and life-cycle service block, compiled through filelist.f
`timescale 1ns/1ps

module fc_lcc_svc_tb;

  import fc_lcc_svc_pkg::*;

  localparam int NUM_ROWS       = 21;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 4 + 200;

  // Short names keep the table rows readable
  localparam awuser_sel_e AW_N = AWUSER_NONE;
  localparam awuser_sel_e AW_C = AWUSER_CORE;
  localparam awuser_sel_e AW_M = AWUSER_MCU;
  localparam zeroize_e    Z_N  = ZEROIZE_NONE;
  localparam zeroize_e    Z_ON = ZEROIZE_ON;
  localparam zeroize_e    Z_RS = ZEROIZE_RESET_STATE;
  localparam svc_cmd_e    CMD_UNKNOWN = svc_cmd_e'(8'hff);

  typedef struct packed {
    svc_cmd_e     cmd;
    logic         ack;
    lc_override_t ov;
    logic [15:0]  freq;
    logic         ext_req;
  } row_t;

  logic         clk;
  logic         cptra_rst_b;
  logic         svc_cmd_valid;
  svc_cmd_e     svc_cmd;
  logic         lc_clk_byp_ack;
  logic         otp_we;
  logic [5:0]   otp_waddr;
  otp_word_t    otp_wdata;
  logic [5:0]   otp_raddr;
  lc_override_t lc_override;
  clk_sel_t     clk_sel;
  logic         clk_switch_req;
  logic         fc_lcc_rst_b;
  logic         disable_sva;
  logic         fault_active;
  otp_word_t    otp_rdata;

  row_t      rows [NUM_ROWS];
  int        n_rows = 0;
  int        cycle_cnt = 0;
  otp_word_t shadow [64];
  logic      part_locked [NUM_PARTS];

  fc_lcc_svc_top i_dut (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .svc_cmd_valid_i  (svc_cmd_valid),
    .svc_cmd_i        (svc_cmd),
    .lc_clk_byp_ack_i (lc_clk_byp_ack),
    .otp_we_i         (otp_we),
    .otp_waddr_i      (otp_waddr),
    .otp_wdata_i      (otp_wdata),
    .otp_raddr_i      (otp_raddr),
    .lc_override_o    (lc_override),
    .clk_sel_o        (clk_sel),
    .clk_switch_req_o (clk_switch_req),
    .fc_lcc_rst_b_o   (fc_lcc_rst_b),
    .disable_sva_o    (disable_sva),
    .fault_active_o   (fault_active),
    .otp_rdata_o      (otp_rdata)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $fatal(1, "Run aborted by the cycle limit");
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Flag bits 5 down to 0 are tokens, rma_scrap_ppd, fc_escalate, lc_esc0, lc_esc1, bus_ecc
  task automatic add_row(input svc_cmd_e cmd, input logic ack, input awuser_sel_e aw,
                         input zeroize_e zr, input logic [5:0] flags,
                         input logic [15:0] freq, input logic ext_req);
    rows[n_rows] = '{cmd, ack, lc_override_t'({aw, zr, flags}), freq, ext_req};
    n_rows++;
  endtask

  task automatic build_table();
    add_row(CMD_FORCE_AWUSER_CORE, 1'b0, AW_C, Z_N, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_FORCE_AWUSER_MCU, 1'b0, AW_M, Z_N, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_FORCE_AWUSER_CORE, 1'b0, AW_C, Z_N, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_RELEASE_AWUSER, 1'b0, AW_N, Z_N, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_FORCE_ZEROIZE, 1'b0, AW_N, Z_ON, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_FORCE_ZEROIZE_RESET, 1'b0, AW_N, Z_RS, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_RELEASE_ZEROIZE, 1'b0, AW_N, Z_N, 6'b000000, 16'd1000, 1'b0);
    add_row(CMD_FORCE_LC_TOKENS, 1'b0, AW_N, Z_N, 6'b100000, 16'd1000, 1'b0);
    add_row(CMD_FORCE_RMA_SCRAP_PPD, 1'b0, AW_N, Z_N, 6'b110000, 16'd1000, 1'b0);
    add_row(CMD_FC_ESCALATE, 1'b0, AW_N, Z_N, 6'b111000, 16'd1000, 1'b0);
    add_row(CMD_LC_ESCALATE0, 1'b0, AW_N, Z_N, 6'b111100, 16'd1000, 1'b0);
    add_row(CMD_LC_ESCALATE1, 1'b0, AW_N, Z_N, 6'b111110, 16'd1000, 1'b0);
    add_row(CMD_FORCE_AWUSER_MCU, 1'b0, AW_M, Z_N, 6'b111110, 16'd1000, 1'b0);
    // An acknowledge retires a pending clock request unless a clock command arrives
    add_row(CMD_EXT_CLK_160, 1'b0, AW_M, Z_N, 6'b111110, 16'd160, 1'b1);
    add_row(CMD_UNKNOWN, 1'b1, AW_M, Z_N, 6'b111110, 16'd160, 1'b0);
    add_row(CMD_EXT_CLK_400, 1'b0, AW_M, Z_N, 6'b111110, 16'd400, 1'b1);
    add_row(CMD_EXT_CLK_500, 1'b1, AW_M, Z_N, 6'b111110, 16'd500, 1'b1);
    add_row(CMD_UNKNOWN, 1'b1, AW_M, Z_N, 6'b111110, 16'd500, 1'b0);
    add_row(CMD_EXT_CLK_1000, 1'b0, AW_M, Z_N, 6'b111110, 16'd1000, 1'b1);
    add_row(CMD_UNKNOWN, 1'b1, AW_M, Z_N, 6'b111110, 16'd1000, 1'b0);
    add_row(CMD_RELEASE_AWUSER, 1'b0, AW_N, Z_N, 6'b111110, 16'd1000, 1'b0);
  endtask

  task automatic apply_reset();
    cptra_rst_b = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    cptra_rst_b = 1'b1;
  endtask

  task automatic send_cmd(input svc_cmd_e cmd);
    @(posedge clk);
    #1;
    svc_cmd_valid = 1'b1;
    svc_cmd       = cmd;
    @(posedge clk);
    #1;
    svc_cmd_valid = 1'b0;
  endtask

  task automatic write_word(input logic [5:0] addr, input otp_word_t data);
    @(posedge clk);
    #1;
    otp_we    = 1'b1;
    otp_waddr = addr;
    otp_wdata = data;
    @(posedge clk);
    #1;
    otp_we       = 1'b0;
    shadow[addr] = data;
  endtask

  task automatic read_check(input logic [5:0] addr, input otp_word_t exp, input string what);
    @(posedge clk);
    #1;
    otp_raddr = addr;
    #10;
    check_value(what, 32'(otp_rdata), 32'(exp));
  endtask

  task automatic load_memory();
    otp_word_t data;
    otp_word_t digest;
    for (int p = 0; p < NUM_PARTS; p++) begin
      data   = 16'($urandom);
      digest = 16'h0000;
      // Partitions 0, 2, 5 and 7 get a digest and count as locked
      if (p == 0 || p == 2 || p == 5 || p == 7) digest = 16'($urandom) | 16'h0001;
      write_word(6'(p * 8), data);
      write_word(6'(p * 8 + 7), digest);
      part_locked[p] = (digest != 16'h0000);
    end
  endtask

  // Mode 0 reads plain words, mode 1 expects the correctable flip, mode 2 the full inversion
  task automatic check_offsets(input int mode);
    otp_word_t exp;
    for (int p = 0; p < NUM_PARTS; p++) begin
      exp = shadow[p * 8];
      if (part_locked[p] && mode == 1) exp[0] = ~exp[0];
      if (part_locked[p] && mode == 2) exp = ~exp;
      read_check(6'(p * 8), exp, $sformatf("partition %0d offset word", p));
    end
  endtask

  task automatic run_table();
    logic prev_ext;
    prev_ext = 1'b0;
    for (int i = 0; i < n_rows; i++) begin
      svc_cmd_valid  = 1'b1;
      svc_cmd        = rows[i].cmd;
      lc_clk_byp_ack = rows[i].ack;
      #1;
      check_value($sformatf("row %0d clk_switch_req_o", i), 32'(clk_switch_req),
                  32'(rows[i].ack & prev_ext));
      @(posedge clk);
      #1;
      check_value($sformatf("row %0d lc_override_o", i), 32'(lc_override), 32'(rows[i].ov));
      check_value($sformatf("row %0d freq_mhz", i), 32'(clk_sel.freq_mhz), 32'(rows[i].freq));
      check_value($sformatf("row %0d ext_req", i), 32'(clk_sel.ext_req), 32'(rows[i].ext_req));
      prev_ext = rows[i].ext_req;
    end
    svc_cmd_valid  = 1'b0;
    lc_clk_byp_ack = 1'b0;
  endtask

  initial begin
    otp_word_t ecc_data;
    otp_word_t plain_data;
    clk            = 1'b0;
    cptra_rst_b    = 1'b0;
    svc_cmd_valid  = 1'b0;
    svc_cmd        = CMD_UNKNOWN;
    lc_clk_byp_ack = 1'b0;
    otp_we         = 1'b0;
    otp_waddr      = '0;
    otp_wdata      = '0;
    otp_raddr      = '0;
    void'($urandom(32'h9783ff56));
    build_table();
    apply_reset();
    check_value("lc_override_o after reset", 32'(lc_override), 32'h0);
    check_value("freq_mhz after reset", 32'(clk_sel.freq_mhz), 32'd1000);
    check_value("ext_req after reset", 32'(clk_sel.ext_req), 32'h0);
    check_value("fc_lcc_rst_b_o after reset", 32'(fc_lcc_rst_b), 32'h1);
    check_value("disable_sva_o after reset", 32'(disable_sva), 32'h0);

    run_table();

    // ----------------------------------------
    // Reset pulse and assertion disable
    // ----------------------------------------
    send_cmd(CMD_FC_LCC_RESET);
    check_value("fc_lcc_rst_b_o at pulse start", 32'(fc_lcc_rst_b), 32'h0);
    for (int k = 1; k <= 11; k++) begin
      // A second reset command in the middle of the pulse
      if (k == 5) begin
        svc_cmd_valid = 1'b1;
        svc_cmd       = CMD_FC_LCC_RESET;
      end
      @(posedge clk);
      #1;
      svc_cmd_valid = 1'b0;
      check_value($sformatf("fc_lcc_rst_b_o %0d cycles into the pulse", k),
                  32'(fc_lcc_rst_b), 32'(k == 11));
    end
    send_cmd(CMD_DISABLE_SVA);
    check_value("disable_sva_o after disable", 32'(disable_sva), 32'h1);
    send_cmd(CMD_ENABLE_SVA);
    check_value("disable_sva_o after enable", 32'(disable_sva), 32'h0);

    // ----------------------------------------
    // OTP faults
    // ----------------------------------------
    load_memory();
    check_offsets(0);
    send_cmd(CMD_CORRECTABLE_FAULT);
    check_value("fault_active_o", 32'(fault_active), 32'h1);
    check_offsets(1);
    send_cmd(CMD_UNCORRECTABLE_FAULT);
    check_offsets(1);

    apply_reset();
    check_value("fault_active_o after reset", 32'(fault_active), 32'h0);
    read_check(6'd0, 16'h0000, "offset 0 after reset");
    load_memory();
    send_cmd(CMD_UNCORRECTABLE_FAULT);
    check_offsets(2);
    send_cmd(CMD_FAULT_BUS_ECC);
    check_value("bus_ecc_fault", 32'(lc_override.bus_ecc_fault), 32'h1);
    ecc_data = 16'($urandom);
    write_word(ECC_FAULT_ADDR, ecc_data);
    read_check(ECC_FAULT_ADDR, ecc_data ^ 16'h0001, "word at the bus ECC fault address");
    plain_data = 16'($urandom);
    write_word(6'd12, plain_data);
    read_check(6'd12, plain_data, "word at address 12");

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* testbench/fc_lcc_svc_properties.sv */
// Concurrent checks on the service block outputs, bound into the top level by the testbench build
`timescale 1ns/1ps

module fc_lcc_svc_properties (
  input logic                      clk,
  input logic                      cptra_rst_b,
  input fc_lcc_svc_pkg::svc_req_t  svc_req_i,
  input fc_lcc_svc_pkg::clk_sel_t  clk_sel_i,
  input logic                      clk_switch_req_i,
  input logic                      fc_lcc_rst_b_i,
  input logic                      fault_active_i
);

  int   low_cnt;
  logic clk_cmd;

  assign clk_cmd = svc_req_i.clk_160 | svc_req_i.clk_400 | svc_req_i.clk_500 |
                   svc_req_i.clk_1000;

  // Length of the current low phase of the subsystem reset
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      low_cnt <= 0;
    end else if (!fc_lcc_rst_b_i) begin
      low_cnt <= low_cnt + 1;
    end else begin
      low_cnt <= 0;
    end
  end

  a_rst_pulse_len: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $rose(fc_lcc_rst_b_i) |-> low_cnt == 11)
    else $error("Subsystem reset pulse was not 11 cycles long");

  a_switch_retires: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    (clk_switch_req_i && !clk_cmd) |=> !clk_sel_i.ext_req)
    else $error("Clock switch request did not clear ext_req");

  a_fault_sticky: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    fault_active_i |=> fault_active_i)
    else $error("fault_active fell outside reset");

endmodule

bind fc_lcc_svc_top fc_lcc_svc_properties i_properties (
  .clk              (clk),
  .cptra_rst_b      (cptra_rst_b),
  .svc_req_i        (svc_req),
  .clk_sel_i        (clk_sel_o),
  .clk_switch_req_i (clk_switch_req_o),
  .fc_lcc_rst_b_i   (fc_lcc_rst_b_o),
  .fault_active_i   (fault_active_o)
);

/* hw/fc_lcc_svc_top.sv */
// Fuse and life-cycle service block top level; connects the command decoder to all service blocks
`timescale 1ns/1ps

module fc_lcc_svc_top (
  input  logic                               clk,
  input  logic                               cptra_rst_b,
  input  logic                               svc_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_e           svc_cmd_i,
  input  logic                               lc_clk_byp_ack_i,
  input  logic                               otp_we_i,
  input  logic [fc_lcc_svc_pkg::OTP_AW-1:0]  otp_waddr_i,
  input  fc_lcc_svc_pkg::otp_word_t          otp_wdata_i,
  input  logic [fc_lcc_svc_pkg::OTP_AW-1:0]  otp_raddr_i,
  output fc_lcc_svc_pkg::lc_override_t       lc_override_o,
  output fc_lcc_svc_pkg::clk_sel_t           clk_sel_o,
  output logic                               clk_switch_req_o,
  output logic                               fc_lcc_rst_b_o,
  output logic                               disable_sva_o,
  output logic                               fault_active_o,
  output fc_lcc_svc_pkg::otp_word_t          otp_rdata_o
);

  import fc_lcc_svc_pkg::*;

  localparam int MEM_DEPTH = 64;

  svc_req_t       svc_req;
  otp_part_view_t part_view [NUM_PARTS];
  otp_word_t      faulted_word [NUM_PARTS];

  // ----------------------------------------
  // Command path
  // ----------------------------------------
  svc_cmd_decoder i_decoder (
    .svc_cmd_valid_i (svc_cmd_valid_i),
    .svc_cmd_i       (svc_cmd_i),
    .svc_req_o       (svc_req)
  );

  lc_override_regs i_override (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .svc_req_i     (svc_req),
    .lc_override_o (lc_override_o)
  );

  lcc_clk_switch_ctrl i_clk_switch (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .svc_req_i        (svc_req),
    .lc_clk_byp_ack_i (lc_clk_byp_ack_i),
    .clk_sel_o        (clk_sel_o),
    .clk_switch_req_o (clk_switch_req_o)
  );

  fc_lcc_reset_seq i_reset_seq (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .svc_req_i      (svc_req),
    .fc_lcc_rst_b_o (fc_lcc_rst_b_o),
    .disable_sva_o  (disable_sva_o)
  );

  // ----------------------------------------
  // OTP model and fault injection
  // ----------------------------------------
  otp_fault_injector #(
    .NUM_PARTS_P (NUM_PARTS)
  ) i_fault_inj (
    .clk            (clk),
    .cptra_rst_b    (cptra_rst_b),
    .svc_req_i      (svc_req),
    .part_view_i    (part_view),
    .fault_active_o (fault_active_o),
    .faulted_word_o (faulted_word)
  );

  otp_mem_model #(
    .OTP_DEPTH (MEM_DEPTH)
  ) i_otp_mem (
    .clk             (clk),
    .cptra_rst_b     (cptra_rst_b),
    .we_i            (otp_we_i),
    .waddr_i         (otp_waddr_i),
    .wdata_i         (otp_wdata_i),
    .raddr_i         (otp_raddr_i),
    .bus_ecc_fault_i (lc_override_o.bus_ecc_fault),
    .fault_active_i  (fault_active_o),
    .faulted_word_i  (faulted_word),
    .rdata_o         (otp_rdata_o),
    .part_view_o     (part_view)
  );

endmodule

/* hw/otp_mem_model.sv */
// OTP word memory with bus ECC write corruption and a faulted read override per partition
`timescale 1ns/1ps

module otp_mem_model #(
  parameter int OTP_DEPTH = 64
) (
  input  logic                                clk,
  input  logic                                cptra_rst_b,
  input  logic                                we_i,
  input  logic [fc_lcc_svc_pkg::OTP_AW-1:0]   waddr_i,
  input  fc_lcc_svc_pkg::otp_word_t           wdata_i,
  input  logic [fc_lcc_svc_pkg::OTP_AW-1:0]   raddr_i,
  input  logic                                bus_ecc_fault_i,
  input  logic                                fault_active_i,
  input  fc_lcc_svc_pkg::otp_word_t           faulted_word_i [fc_lcc_svc_pkg::NUM_PARTS],
  output fc_lcc_svc_pkg::otp_word_t           rdata_o,
  output fc_lcc_svc_pkg::otp_part_view_t      part_view_o [fc_lcc_svc_pkg::NUM_PARTS]
);

  import fc_lcc_svc_pkg::*;

  otp_word_t mem [OTP_DEPTH];
  logic      ecc_flip;

  // Armed bus ECC fault corrupts bit 0 of one write address
  assign ecc_flip = bus_ecc_fault_i && (waddr_i == ECC_FAULT_ADDR);

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      for (int i = 0; i < OTP_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (we_i) begin
      mem[waddr_i] <= wdata_i ^ {15'd0, ecc_flip};
    end
  end

  always_comb begin
    rdata_o = mem[raddr_i];
    for (int i = 0; i < NUM_PARTS; i++) begin
      if (fault_active_i && (raddr_i == PART_OFFSET[i])) begin
        rdata_o = faulted_word_i[i];
      end
      part_view_o[i].data   = mem[PART_OFFSET[i]];
      part_view_o[i].locked = |mem[PART_DIGEST[i]];
    end
  end

endmodule

/* hw/otp_fault_injector.sv */
// Latches faulted copies of the partition offset words on the first fault command
`timescale 1ns/1ps

module otp_fault_injector #(
  parameter int NUM_PARTS_P = 8
) (
  input  logic                            clk,
  input  logic                            cptra_rst_b,
  input  fc_lcc_svc_pkg::svc_req_t        svc_req_i,
  input  fc_lcc_svc_pkg::otp_part_view_t  part_view_i [NUM_PARTS_P],
  output logic                            fault_active_o,
  output fc_lcc_svc_pkg::otp_word_t       faulted_word_o [NUM_PARTS_P]
);

  import fc_lcc_svc_pkg::*;

  logic      fault_active_q;
  logic      capture;
  otp_word_t faulted_word_q [NUM_PARTS_P];
  otp_word_t fault_next [NUM_PARTS_P];

  assign capture = (svc_req_i.correctable_fault | svc_req_i.uncorrectable_fault)
                   & ~fault_active_q;

  // ----------------------------------------
  // Fault rules for locked partitions
  // ----------------------------------------
  always_comb begin
    for (int i = 0; i < NUM_PARTS_P; i++) begin
      if (svc_req_i.uncorrectable_fault) begin
        fault_next[i] = part_view_i[i].data ^ {16{part_view_i[i].locked}};
      end else begin
        // Single bit flip, which ECC can still repair
        fault_next[i] = {part_view_i[i].data[15:1],
                         part_view_i[i].data[0] ^ part_view_i[i].locked};
      end
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_active_q <= 1'b0;
    end else if (capture) begin
      fault_active_q <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      for (int i = 0; i < NUM_PARTS_P; i++) begin
        faulted_word_q[i] <= fault_next[i];
      end
    end
  end

  assign fault_active_o = fault_active_q;
  assign faulted_word_o = faulted_word_q;

endmodule

/* hw/fc_lcc_reset_seq.sv */
// Produces the 11-cycle fuse and life-cycle reset pulse and holds the assertion-disable level
`timescale 1ns/1ps

module fc_lcc_reset_seq (
  input  logic                      clk,
  input  logic                      cptra_rst_b,
  input  fc_lcc_svc_pkg::svc_req_t  svc_req_i,
  output logic                      fc_lcc_rst_b_o,
  output logic                      disable_sva_o
);

  import fc_lcc_svc_pkg::*;

  // The pulse covers counter values 0 through RST_LAST
  localparam logic [3:0] RST_LAST = 4'd10;

  logic [3:0] rst_cnt_q;
  logic       rst_active_q;
  logic       disable_sva_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      rst_active_q <= 1'b0;
      rst_cnt_q    <= '0;
    end else if (rst_active_q) begin
      // Further reset commands are dropped while the pulse runs
      if (rst_cnt_q == RST_LAST) begin
        rst_active_q <= 1'b0;
        rst_cnt_q    <= '0;
      end else begin
        rst_cnt_q <= rst_cnt_q + 4'd1;
      end
    end else if (svc_req_i.fc_lcc_reset) begin
      rst_active_q <= 1'b1;
      rst_cnt_q    <= '0;
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      disable_sva_q <= 1'b0;
    end else if (svc_req_i.disable_sva) begin
      disable_sva_q <= 1'b1;
    end else if (svc_req_i.enable_sva) begin
      disable_sva_q <= 1'b0;
    end
  end

  assign fc_lcc_rst_b_o = ~rst_active_q;
  assign disable_sva_o  = disable_sva_q;

endmodule

/* hw/lcc_clk_switch_ctrl.sv */
// External clock frequency selection and the clock switch request toward the life-cycle controller
`timescale 1ns/1ps

module lcc_clk_switch_ctrl (
  input  logic                      clk,
  input  logic                      cptra_rst_b,
  input  fc_lcc_svc_pkg::svc_req_t  svc_req_i,
  input  logic                      lc_clk_byp_ack_i,
  output fc_lcc_svc_pkg::clk_sel_t  clk_sel_o,
  output logic                      clk_switch_req_o
);

  import fc_lcc_svc_pkg::*;

  clk_sel_t    clk_sel_q;
  logic        clk_cmd;
  logic [15:0] clk_freq;

  always_comb begin
    clk_cmd  = 1'b1;
    clk_freq = CLK_MHZ_DEFAULT;
    if (svc_req_i.clk_160)       clk_freq = 16'd160;
    else if (svc_req_i.clk_400)  clk_freq = 16'd400;
    else if (svc_req_i.clk_500)  clk_freq = 16'd500;
    else if (svc_req_i.clk_1000) clk_freq = 16'd1000;
    else                         clk_cmd  = 1'b0;
  end

  // A new clock command beats the retirement of the pending request
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_q.freq_mhz <= CLK_MHZ_DEFAULT;
      clk_sel_q.ext_req  <= 1'b0;
    end else if (clk_cmd) begin
      clk_sel_q.freq_mhz <= clk_freq;
      clk_sel_q.ext_req  <= 1'b1;
    end else if (clk_switch_req_o) begin
      clk_sel_q.ext_req  <= 1'b0;
    end
  end

  assign clk_switch_req_o = lc_clk_byp_ack_i & clk_sel_q.ext_req;
  assign clk_sel_o        = clk_sel_q;

endmodule

/* hw/lc_override_regs.sv */
// Sticky override levels for the fuse and life-cycle controllers, set and released by commands
`timescale 1ns/1ps

module lc_override_regs (
  input  logic                          clk,
  input  logic                          cptra_rst_b,
  input  fc_lcc_svc_pkg::svc_req_t      svc_req_i,
  output fc_lcc_svc_pkg::lc_override_t  lc_override_o
);

  import fc_lcc_svc_pkg::*;

  lc_override_t ov_q;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ov_q <= '0;
    end else begin
      // The latest command of the write-user group wins
      if (svc_req_i.awuser_core) begin
        ov_q.awuser_sel <= AWUSER_CORE;
      end else if (svc_req_i.awuser_mcu) begin
        ov_q.awuser_sel <= AWUSER_MCU;
      end else if (svc_req_i.awuser_release) begin
        ov_q.awuser_sel <= AWUSER_NONE;
      end

      if (svc_req_i.zeroize) begin
        ov_q.zeroize <= ZEROIZE_ON;
      end else if (svc_req_i.zeroize_reset) begin
        ov_q.zeroize <= ZEROIZE_RESET_STATE;
      end else if (svc_req_i.zeroize_release) begin
        ov_q.zeroize <= ZEROIZE_NONE;
      end

      // The remaining levels have no release and hold until reset
      if (svc_req_i.lc_tokens)     ov_q.tokens_force  <= 1'b1;
      if (svc_req_i.rma_scrap_ppd) ov_q.rma_scrap_ppd <= 1'b1;
      if (svc_req_i.fc_escalate)   ov_q.fc_escalate   <= 1'b1;
      if (svc_req_i.lc_esc0)       ov_q.lc_esc0       <= 1'b1;
      if (svc_req_i.lc_esc1)       ov_q.lc_esc1       <= 1'b1;
      if (svc_req_i.bus_ecc_fault) ov_q.bus_ecc_fault <= 1'b1;
    end
  end

  assign lc_override_o = ov_q;

endmodule

/* hw/svc_cmd_decoder.sv */
// Decodes a valid service command byte into one request pulse for the register blocks
`timescale 1ns/1ps

module svc_cmd_decoder (
  input  logic                      svc_cmd_valid_i,
  input  fc_lcc_svc_pkg::svc_cmd_e  svc_cmd_i,
  output fc_lcc_svc_pkg::svc_req_t  svc_req_o
);

  import fc_lcc_svc_pkg::*;

  // Unknown codes leave every field low
  always_comb begin
    svc_req_o = '0;
    if (svc_cmd_valid_i) begin
      case (svc_cmd_i)
        CMD_FORCE_AWUSER_CORE:   svc_req_o.awuser_core         = 1'b1;
        CMD_FORCE_AWUSER_MCU:    svc_req_o.awuser_mcu          = 1'b1;
        CMD_RELEASE_AWUSER:      svc_req_o.awuser_release      = 1'b1;
        CMD_FORCE_ZEROIZE:       svc_req_o.zeroize             = 1'b1;
        CMD_FORCE_ZEROIZE_RESET: svc_req_o.zeroize_reset       = 1'b1;
        CMD_RELEASE_ZEROIZE:     svc_req_o.zeroize_release     = 1'b1;
        CMD_FORCE_LC_TOKENS:     svc_req_o.lc_tokens           = 1'b1;
        CMD_FORCE_RMA_SCRAP_PPD: svc_req_o.rma_scrap_ppd       = 1'b1;
        CMD_FC_ESCALATE:         svc_req_o.fc_escalate         = 1'b1;
        CMD_LC_ESCALATE0:        svc_req_o.lc_esc0             = 1'b1;
        CMD_LC_ESCALATE1:        svc_req_o.lc_esc1             = 1'b1;
        CMD_EXT_CLK_160:         svc_req_o.clk_160             = 1'b1;
        CMD_EXT_CLK_400:         svc_req_o.clk_400             = 1'b1;
        CMD_EXT_CLK_500:         svc_req_o.clk_500             = 1'b1;
        CMD_EXT_CLK_1000:        svc_req_o.clk_1000            = 1'b1;
        CMD_FC_LCC_RESET:        svc_req_o.fc_lcc_reset        = 1'b1;
        CMD_FAULT_BUS_ECC:       svc_req_o.bus_ecc_fault       = 1'b1;
        CMD_DISABLE_SVA:         svc_req_o.disable_sva         = 1'b1;
        CMD_ENABLE_SVA:          svc_req_o.enable_sva          = 1'b1;
        CMD_CORRECTABLE_FAULT:   svc_req_o.correctable_fault   = 1'b1;
        CMD_UNCORRECTABLE_FAULT: svc_req_o.uncorrectable_fault = 1'b1;
        default: begin
        end
      endcase
    end
  end

endmodule

/* hw/fc_lcc_svc_pkg.sv */
// Shared command codes, override structs and OTP partition map, imported by every service block
package fc_lcc_svc_pkg;

  // ----------------------------------------
  // Command codes
  // ----------------------------------------
  typedef enum logic [7:0] {
    CMD_FORCE_AWUSER_CORE   = 8'h01,
    CMD_FORCE_AWUSER_MCU    = 8'h02,
    CMD_RELEASE_AWUSER      = 8'h03,
    CMD_FORCE_ZEROIZE       = 8'h04,
    CMD_FORCE_ZEROIZE_RESET = 8'h05,
    CMD_RELEASE_ZEROIZE     = 8'h06,
    CMD_FORCE_LC_TOKENS     = 8'h07,
    CMD_FORCE_RMA_SCRAP_PPD = 8'h08,
    CMD_FC_ESCALATE         = 8'h09,
    CMD_LC_ESCALATE0        = 8'h0a,
    CMD_LC_ESCALATE1        = 8'h0b,
    CMD_EXT_CLK_160         = 8'h0c,
    CMD_EXT_CLK_400         = 8'h0d,
    CMD_EXT_CLK_500         = 8'h0e,
    CMD_EXT_CLK_1000        = 8'h0f,
    CMD_FC_LCC_RESET        = 8'h10,
    CMD_FAULT_BUS_ECC       = 8'h11,
    CMD_DISABLE_SVA         = 8'h12,
    CMD_ENABLE_SVA          = 8'h13,
    CMD_CORRECTABLE_FAULT   = 8'h14,
    CMD_UNCORRECTABLE_FAULT = 8'h15
  } svc_cmd_e;

  // One single-cycle pulse per decoded command
  typedef struct packed {
    logic awuser_core;
    logic awuser_mcu;
    logic awuser_release;
    logic zeroize;
    logic zeroize_reset;
    logic zeroize_release;
    logic lc_tokens;
    logic rma_scrap_ppd;
    logic fc_escalate;
    logic lc_esc0;
    logic lc_esc1;
    logic clk_160;
    logic clk_400;
    logic clk_500;
    logic clk_1000;
    logic fc_lcc_reset;
    logic bus_ecc_fault;
    logic disable_sva;
    logic enable_sva;
    logic correctable_fault;
    logic uncorrectable_fault;
  } svc_req_t;

  typedef enum logic [1:0] {
    AWUSER_NONE = 2'd0,
    AWUSER_CORE = 2'd1,
    AWUSER_MCU  = 2'd2
  } awuser_sel_e;

  typedef enum logic [1:0] {
    ZEROIZE_NONE        = 2'd0,
    ZEROIZE_ON          = 2'd1,
    ZEROIZE_RESET_STATE = 2'd2
  } zeroize_e;

  typedef struct packed {
    awuser_sel_e awuser_sel;
    zeroize_e    zeroize;
    logic        tokens_force;
    logic        rma_scrap_ppd;
    logic        fc_escalate;
    logic        lc_esc0;
    logic        lc_esc1;
    logic        bus_ecc_fault;
  } lc_override_t;

  typedef struct packed {
    logic [15:0] freq_mhz;
    logic        ext_req;
  } clk_sel_t;

  typedef logic [15:0] otp_word_t;

  // Offset word of a partition together with its digest lock
  typedef struct packed {
    otp_word_t data;
    logic      locked;
  } otp_part_view_t;

  // ----------------------------------------
  // OTP partition map
  // ----------------------------------------
  parameter int NUM_PARTS = 8;
  parameter int OTP_AW    = 6;

  parameter logic [OTP_AW-1:0] PART_OFFSET [NUM_PARTS] = '{
    6'd0, 6'd8, 6'd16, 6'd24, 6'd32, 6'd40, 6'd48, 6'd56
  };
  parameter logic [OTP_AW-1:0] PART_DIGEST [NUM_PARTS] = '{
    6'd7, 6'd15, 6'd23, 6'd31, 6'd39, 6'd47, 6'd55, 6'd63
  };

  parameter logic [OTP_AW-1:0] ECC_FAULT_ADDR  = 6'd5;
  parameter logic [15:0]       CLK_MHZ_DEFAULT = 16'd1000;

endpackage
